/* hdl/cmd_fifo.sv */
`timescale 1ns/1ps
`default_nettype none
`include "pulse_list_config.svh"

module cmd_fifo (
  input  logic CLK,
  input  logic RESET,
  input  logic wren,
  input  pulse_list_pkg::ram_cmd_u din,
  input  logic rden,
  output pulse_list_pkg::ram_cmd_u dout,
  output logic empty,
  output logic almost_empty,
  output logic full,
  output logic high
);
  localparam int PTR_W = $clog2(`PL_FIFO_DEPTH);

  pulse_list_pkg::ram_cmd_u mem [`PL_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0] count;  // one extra bit to hold depth
  logic do_wr;
  logic do_rd;

  assign do_wr = wren && !full;  // overflow drops the word
  assign do_rd = rden && !empty;

  always_ff @(posedge CLK) begin
    if (do_wr) mem[wr_ptr] <= din;
  end

  always_ff @(posedge CLK) begin
    if (RESET) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign dout = mem[rd_ptr];  // show-ahead head
  assign empty = count == '0;
  assign almost_empty = count <= (PTR_W+1)'(1);
  assign full = count == (PTR_W+1)'(`PL_FIFO_DEPTH);
  assign high = count >= (PTR_W+1)'(`PL_FIFO_HIGH);

endmodule

`default_nettype wire

/* hdl/msg_assembler.sv */
`timescale 1ns/1ps
`default_nettype none
`include "pulse_list_config.svh"

module msg_assembler (
  input  logic CLK,
  input  logic RESET,
  input  logic pc_msg_valid,
  input  logic [`PL_XB_W-1:0] pc_msg,
  output logic pc_msg_ack,
  output logic start_cmd,
  output logic stop_cmd
);
  localparam int CNT_W = $clog2(`PL_CMD_WORDS);

  logic [CNT_W-1:0] word_cnt;
  logic [(`PL_CMD_WORDS-1)*`PL_XB_W-1:0] cache;  // earlier words of command
  pulse_list_pkg::host_cmd_t cmd;

  assign pc_msg_ack = pc_msg_valid;  // always ready
  assign cmd = {pc_msg, cache};  // valid only with last word

  always_ff @(posedge CLK) begin
    if (RESET) begin
      word_cnt <= '0;
      start_cmd <= 1'b0;
      stop_cmd <= 1'b0;
    end else begin
      start_cmd <= 1'b0;
      stop_cmd <= 1'b0;
      if (pc_msg_valid) begin
        if (word_cnt == CNT_W'(`PL_CMD_WORDS - 1)) begin
          word_cnt <= '0;
          // data commands are dropped
          start_cmd <= !cmd.is_data && cmd.start;
          stop_cmd <= !cmd.is_data && !cmd.start;
        end else begin
          cache[word_cnt*`PL_XB_W +: `PL_XB_W] <= pc_msg;
          word_cnt <= word_cnt + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/pacer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "pulse_list_config.svh"

module pacer (
  input  logic CLK,
  input  logic RESET,
  input  logic start_cmd,
  input  logic stop_cmd,
  output logic [1:0] cmd_wren,
  output pulse_list_pkg::ram_cmd_u [1:0] cmd_din,
  input  logic [1:0] cmd_full,
  input  pulse_list_pkg::ram_cmd_u rd_dout,
  input  logic rd_empty,
  output logic rd_rden,
  input  pulse_list_pkg::ctrl_report_t report0,
  input  pulse_list_pkg::ctrl_report_t report1,
  output logic fpga_msg_valid,
  output logic [`PL_XB_W-1:0] fpga_msg,
  output logic app_running,
  output logic app_error,
  output logic [3:0] GPIO_LED
);
  localparam int CNT_W = `PL_ZMW_W + 1;
  localparam logic [CNT_W-1:0] N_ZMW = CNT_W'(`PL_N_ZMW);

  pulse_list_pkg::pacer_state_e state;
  logic [CNT_W-1:0] wr_cnt;  // next index to fill
  logic [CNT_W-1:0] rd_cnt;  // next index expected back
  logic rd_done;
  logic rd_bad;

  function automatic pulse_list_pkg::ram_cmd_u ctrl_cmd(input logic sof, input logic write);
    pulse_list_pkg::ram_cmd_u c;
    c = '0;
    c.ctrl.sof = sof;
    c.ctrl.write = write;
    return c;
  endfunction

  function automatic pulse_list_pkg::ram_cmd_u data_cmd(input logic [`PL_ZMW_W-1:0] zmw);
    pulse_list_pkg::ram_cmd_u c;
    c = '0;
    c.data.is_data = 1'b1;
    c.data.zmw = zmw;
    return c;
  endfunction

  assign rd_done = rd_cnt == N_ZMW;
  // pop only when the copy or a STOP can go out in the same cycle
  assign rd_rden = state == pulse_list_pkg::PACER_POSTING && !rd_empty && !rd_done
                   && cmd_full == 2'b00;
  assign rd_bad = !rd_dout.data.is_data || rd_dout.data.zmw != rd_cnt[`PL_ZMW_W-1:0];

  assign app_running = state == pulse_list_pkg::PACER_INTERFRAME;
  assign app_error = state == pulse_list_pkg::PACER_ERROR;
  assign GPIO_LED = state;

  always_ff @(posedge CLK) begin
    if (RESET) begin
      state <= pulse_list_pkg::PACER_STOPPED;
      cmd_wren <= 2'b00;
      wr_cnt <= '0;
      rd_cnt <= '0;
      fpga_msg_valid <= 1'b0;
    end else begin
      cmd_wren <= 2'b00;
      fpga_msg_valid <= report0.valid || report1.valid;
      if (report0.valid || report1.valid) begin
        // byte per controller: reported bit on top, state at the bottom
        fpga_msg <= {{(`PL_XB_W-16){1'b0}},
                     report1.valid, 4'b0, report1.state,
                     report0.valid, 4'b0, report0.state};
      end
      case (state)
        pulse_list_pkg::PACER_STOPPED:
          if (start_cmd) state <= pulse_list_pkg::PACER_STARTING;
        pulse_list_pkg::PACER_STARTING:
          if (!cmd_full[0]) begin
            cmd_din[0] <= ctrl_cmd(1'b1, 1'b1);  // START(write)
            cmd_wren[0] <= 1'b1;
            wr_cnt <= '0;
            state <= pulse_list_pkg::PACER_INIT;
          end
        pulse_list_pkg::PACER_INIT:
          if (stop_cmd) begin
            state <= pulse_list_pkg::PACER_STOPPING;
          end else if (cmd_full[0]) begin
            state <= pulse_list_pkg::PACER_INIT_THROTTLED;
          end else if (wr_cnt == N_ZMW) begin
            cmd_din[0] <= ctrl_cmd(1'b0, 1'b0);  // STOP closes the fill
            cmd_wren[0] <= 1'b1;
            state <= pulse_list_pkg::PACER_STARTING_POST;
          end else begin
            cmd_din[0] <= data_cmd(wr_cnt[`PL_ZMW_W-1:0]);
            cmd_wren[0] <= 1'b1;
            wr_cnt <= wr_cnt + 1'b1;
          end
        pulse_list_pkg::PACER_INIT_THROTTLED:
          if (stop_cmd) state <= pulse_list_pkg::PACER_STOPPING;
          else if (!cmd_full[0]) state <= pulse_list_pkg::PACER_INIT;
        pulse_list_pkg::PACER_STARTING_POST:
          if (cmd_full == 2'b00) begin
            cmd_din[0] <= ctrl_cmd(1'b1, 1'b0);  // read back ram 0
            cmd_din[1] <= ctrl_cmd(1'b1, 1'b1);  // copy into ram 1
            cmd_wren <= 2'b11;
            rd_cnt <= '0;
            state <= pulse_list_pkg::PACER_POSTING;
          end
        pulse_list_pkg::PACER_POSTING:
          if (rd_done && cmd_full == 2'b00) begin
            cmd_din <= {ctrl_cmd(1'b0, 1'b0), ctrl_cmd(1'b0, 1'b0)};
            cmd_wren <= 2'b11;
            state <= pulse_list_pkg::PACER_INTERFRAME;
          end else if (rd_rden && rd_bad) begin
            cmd_din <= {ctrl_cmd(1'b0, 1'b0), ctrl_cmd(1'b0, 1'b0)};
            cmd_wren <= 2'b11;
            state <= pulse_list_pkg::PACER_ERROR;
          end else if (rd_rden) begin
            cmd_din[1] <= rd_dout;
            cmd_wren[1] <= 1'b1;
            rd_cnt <= rd_cnt + 1'b1;
          end
        pulse_list_pkg::PACER_INTERFRAME:
          if (stop_cmd) state <= pulse_list_pkg::PACER_STOPPING;
        pulse_list_pkg::PACER_STOPPING:
          if (cmd_full == 2'b00) begin
            cmd_din <= {ctrl_cmd(1'b0, 1'b0), ctrl_cmd(1'b0, 1'b0)};
            cmd_wren <= 2'b11;
            state <= pulse_list_pkg::PACER_STOPPED;
          end
        default: begin
          // error holds until reset
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/pulse_list_app.sv */
`timescale 1ns/1ps
`default_nettype none
`include "pulse_list_config.svh"

module pulse_list_app (
  input  logic CLK,
  input  logic RESET,
  input  logic pc_msg_valid,
  input  logic [`PL_XB_W-1:0] pc_msg,
  output logic pc_msg_ack,
  output logic fpga_msg_valid,
  output logic [`PL_XB_W-1:0] fpga_msg,
  output logic app_running,
  output logic app_error,
  output logic [3:0] GPIO_LED
);
  logic start_cmd;
  logic stop_cmd;
  logic [1:0] cmd_wren;
  logic [1:0] cmd_rden;
  logic [1:0] cmd_full;
  logic [1:0] cmd_empty;
  pulse_list_pkg::ram_cmd_u [1:0] cmd_din;
  pulse_list_pkg::ram_cmd_u [1:0] cmd_head;
  pulse_list_pkg::ram_cmd_u [1:0] ram_wdata;
  logic [1:0][`PL_ZMW_W-1:0] ram_addr;
  logic [1:0] ram_we;
  logic [1:0] ram_re;
  pulse_list_pkg::ctrl_report_t [1:0] report;
  pulse_list_pkg::ram_cmd_u ram0_rdata;
  logic ram0_rd_valid;
  pulse_list_pkg::ram_cmd_u rd_dout;
  logic rd_rden;
  logic rd_empty;
  logic rd_full;
  logic rd_high;

  msg_assembler msg_assembler_inst (
    .CLK(CLK), .RESET(RESET), .pc_msg_valid(pc_msg_valid), .pc_msg(pc_msg),
    .pc_msg_ack(pc_msg_ack), .start_cmd(start_cmd), .stop_cmd(stop_cmd));

  pacer pacer_inst (
    .CLK(CLK), .RESET(RESET), .start_cmd(start_cmd), .stop_cmd(stop_cmd),
    .cmd_wren(cmd_wren), .cmd_din(cmd_din), .cmd_full(cmd_full),
    .rd_dout(rd_dout), .rd_empty(rd_empty), .rd_rden(rd_rden),
    .report0(report[0]), .report1(report[1]),
    .fpga_msg_valid(fpga_msg_valid), .fpga_msg(fpga_msg),
    .app_running(app_running), .app_error(app_error), .GPIO_LED(GPIO_LED));

  cmd_fifo cmd_fifo_0 (
    .CLK(CLK), .RESET(RESET), .wren(cmd_wren[0]), .din(cmd_din[0]),
    .rden(cmd_rden[0]), .dout(cmd_head[0]), .empty(cmd_empty[0]),
    .almost_empty(), .full(cmd_full[0]), .high());

  cmd_fifo cmd_fifo_1 (
    .CLK(CLK), .RESET(RESET), .wren(cmd_wren[1]), .din(cmd_din[1]),
    .rden(cmd_rden[1]), .dout(cmd_head[1]), .empty(cmd_empty[1]),
    .almost_empty(), .full(cmd_full[1]), .high());

  cmd_fifo from_ram_fifo (
    .CLK(CLK), .RESET(RESET), .wren(ram0_rd_valid), .din(ram0_rdata),
    .rden(rd_rden), .dout(rd_dout), .empty(rd_empty),
    .almost_empty(), .full(rd_full), .high(rd_high));

  ram_controller ram_controller_0 (
    .CLK(CLK), .RESET(RESET), .cmd(cmd_head[0]), .cmd_empty(cmd_empty[0]),
    .cmd_rden(cmd_rden[0]), .ram_addr(ram_addr[0]), .ram_wdata(ram_wdata[0]),
    .ram_we(ram_we[0]), .ram_re(ram_re[0]), .rd_high(rd_high), .rd_full(rd_full),
    .report(report[0]));

  // ram 1 is never read back
  ram_controller ram_controller_1 (
    .CLK(CLK), .RESET(RESET), .cmd(cmd_head[1]), .cmd_empty(cmd_empty[1]),
    .cmd_rden(cmd_rden[1]), .ram_addr(ram_addr[1]), .ram_wdata(ram_wdata[1]),
    .ram_we(ram_we[1]), .ram_re(ram_re[1]), .rd_high(1'b0), .rd_full(1'b0),
    .report(report[1]));

  pulse_list_ram pulse_list_ram_0 (
    .CLK(CLK), .addr(ram_addr[0]), .wdata(ram_wdata[0]), .we(ram_we[0]),
    .re(ram_re[0]), .rdata(ram0_rdata), .rd_valid(ram0_rd_valid));

  pulse_list_ram pulse_list_ram_1 (
    .CLK(CLK), .addr(ram_addr[1]), .wdata(ram_wdata[1]), .we(ram_we[1]),
    .re(ram_re[1]), .rdata(), .rd_valid());

endmodule

`default_nettype wire

/* hdl/pulse_list_config.svh */
`ifndef PULSE_LIST_CONFIG_SVH
`define PULSE_LIST_CONFIG_SVH

`define PL_XB_W 32  // host word width
`define PL_CMD_WORDS 3  // host words per command

`define PL_RAM_W 16  // ram and fifo word, low byte is header
`define PL_N_ZMW 128  // entries per ram
`define PL_ZMW_W 7

`define PL_FIFO_DEPTH 16  // power of two
`define PL_FIFO_HIGH 12  // throttle level of from-ram fifo

`define PL_RAM_LATENCY 5  // re to rdata, in clocks

`endif

/* hdl/pulse_list_pkg.sv */
`default_nettype none
`include "pulse_list_config.svh"

package pulse_list_pkg;

  // first host word sits in the low bits
  typedef struct packed {
    logic [`PL_XB_W*`PL_CMD_WORDS-8:0] fields;  // not decoded here
    logic start;  // 1 start, 0 stop
    logic [4:0] rsvd;
    logic is_data;  // 0 control, 1 data
  } host_cmd_t;

  typedef struct packed {
    logic [`PL_RAM_W-4:0] rsvd;
    logic write;  // sof only, 1 write, 0 read
    logic sof;  // 0 means STOP
    logic is_data;  // always 0 here
  } ram_ctrl_t;

  typedef struct packed {
    logic [`PL_RAM_W-`PL_ZMW_W-9:0] pad;
    logic [`PL_ZMW_W-1:0] zmw;  // payload starts above header byte
    logic [6:0] rsvd;
    logic is_data;  // always 1 here
  } ram_data_t;

  typedef union packed {
    ram_ctrl_t ctrl;
    ram_data_t data;
  } ram_cmd_u;

  typedef enum logic [2:0] {
    RAM_ERROR, RAM_IDLE, RAM_WRITE, RAM_READING, RAM_THROTTLED
  } ram_state_e;

  // code goes straight to the leds
  typedef enum logic [3:0] {
    PACER_ERROR, PACER_STOPPED, PACER_STOPPING, PACER_STARTING,
    PACER_INIT, PACER_INIT_THROTTLED, PACER_STARTING_POST,
    PACER_POSTING, PACER_INTERFRAME
  } pacer_state_e;

  typedef struct packed {
    logic valid;  // one cycle per STOP seen
    ram_state_e state;  // state when STOP arrived
  } ctrl_report_t;

endpackage

`default_nettype wire

/* hdl/pulse_list_ram.sv */
`timescale 1ns/1ps
`default_nettype none
`include "pulse_list_config.svh"

module pulse_list_ram (
  input  logic CLK,
  input  logic [`PL_ZMW_W-1:0] addr,
  input  pulse_list_pkg::ram_cmd_u wdata,
  input  logic we,
  input  logic re,
  output pulse_list_pkg::ram_cmd_u rdata,
  output logic rd_valid
);
  localparam int LAT = `PL_RAM_LATENCY;

  pulse_list_pkg::ram_cmd_u mem [`PL_N_ZMW];
  pulse_list_pkg::ram_cmd_u rd_pipe [LAT];  // output register stages
  logic [LAT-1:0] vld_pipe;

  always_ff @(posedge CLK) begin
    if (we) mem[addr] <= wdata;
    if (re) rd_pipe[0] <= mem[addr];
    for (int i = 1; i < LAT; i++) rd_pipe[i] <= rd_pipe[i-1];
    vld_pipe <= {vld_pipe[LAT-2:0], re};
  end

  assign rdata = rd_pipe[LAT-1];
  assign rd_valid = vld_pipe[LAT-1];

endmodule

`default_nettype wire

/* hdl/ram_controller.sv */
`timescale 1ns/1ps
`default_nettype none
`include "pulse_list_config.svh"

module ram_controller (
  input  logic CLK,
  input  logic RESET,
  input  pulse_list_pkg::ram_cmd_u cmd,
  input  logic cmd_empty,
  output logic cmd_rden,
  output logic [`PL_ZMW_W-1:0] ram_addr,
  output pulse_list_pkg::ram_cmd_u ram_wdata,
  output logic ram_we,
  output logic ram_re,
  input  logic rd_high,
  input  logic rd_full,
  output pulse_list_pkg::ctrl_report_t report
);
  localparam logic [`PL_ZMW_W-1:0] LAST_ADDR = `PL_ZMW_W'(`PL_N_ZMW - 1);

  pulse_list_pkg::ram_state_e state;
  logic [`PL_ZMW_W-1:0] addr;  // next ram address
  logic is_ctrl;
  logic is_sof;
  logic is_stop;

  // one entry per cycle in every state, unused ones are dropped
  assign cmd_rden = !cmd_empty;
  assign is_ctrl = cmd_rden && !cmd.ctrl.is_data;
  assign is_sof = is_ctrl && cmd.ctrl.sof;
  assign is_stop = is_ctrl && !cmd.ctrl.sof;

  always_ff @(posedge CLK) begin
    if (RESET) begin
      state <= pulse_list_pkg::RAM_IDLE;
      addr <= '0;
      ram_we <= 1'b0;
      ram_re <= 1'b0;
      report <= '0;
    end else begin
      ram_we <= 1'b0;
      ram_re <= 1'b0;
      report.valid <= 1'b0;
      if (is_stop) begin
        report <= '{valid: 1'b1, state: state};  // state before the STOP
        state <= pulse_list_pkg::RAM_IDLE;
      end else begin
        case (state)
          pulse_list_pkg::RAM_IDLE:
            if (is_sof) begin
              addr <= '0;
              state <= cmd.ctrl.write ? pulse_list_pkg::RAM_WRITE
                                      : pulse_list_pkg::RAM_READING;
            end
          pulse_list_pkg::RAM_WRITE:
            if (cmd_rden && cmd.data.is_data) begin
              ram_wdata <= cmd;
              ram_addr <= addr;
              ram_we <= 1'b1;
              addr <= addr + 1'b1;
            end
          pulse_list_pkg::RAM_READING:
            if (rd_full) begin
              state <= pulse_list_pkg::RAM_ERROR;  // read-back data lost
            end else if (rd_high) begin
              state <= pulse_list_pkg::RAM_THROTTLED;
            end else begin
              ram_addr <= addr;
              ram_re <= 1'b1;
              addr <= addr + 1'b1;
              if (addr == LAST_ADDR) state <= pulse_list_pkg::RAM_IDLE;
            end
          pulse_list_pkg::RAM_THROTTLED:
            if (rd_full) state <= pulse_list_pkg::RAM_ERROR;
            else if (!rd_high) state <= pulse_list_pkg::RAM_READING;
          default: begin
            // error, left only by STOP
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the pulse list testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module pulse_list_app_tb \
  -Mdir obj_dir \
  -f sources.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vpulse_list_app_tb
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi
exit 0

/* sources.f */
+incdir+hdl
hdl/pulse_list_pkg.sv
hdl/msg_assembler.sv
hdl/cmd_fifo.sv
hdl/pulse_list_ram.sv
hdl/ram_controller.sv
hdl/pacer.sv
hdl/pulse_list_app.sv
verif/pulse_list_app_props.sv
verif/pulse_list_app_tb.sv

/* verif/pulse_list_app_props.sv */
`timescale 1ns/1ps
`default_nettype none

module pulse_list_app_props (
  input logic CLK,
  input logic RESET,
  input logic pc_msg_valid,
  input logic pc_msg_ack,
  input logic fpga_msg_valid,
  input logic app_running,
  input logic app_error,
  input logic [3:0] GPIO_LED
);

  ack_follows_valid: assert property (@(posedge CLK) disable iff (RESET)
    pc_msg_ack == pc_msg_valid)
    else $error("pc_msg_ack differs from pc_msg_valid");

  running_error_exclusive: assert property (@(posedge CLK) disable iff (RESET)
    !(app_running && app_error))
    else $error("app_running and app_error high together");

  status_single_pulse: assert property (@(posedge CLK) disable iff (RESET)
    fpga_msg_valid |=> !fpga_msg_valid)
    else $error("fpga_msg_valid held for two cycles");

  // codes above interframe are unused
  led_code_legal: assert property (@(posedge CLK) disable iff (RESET)
    GPIO_LED <= pulse_list_pkg::PACER_INTERFRAME)
    else $error("GPIO_LED shows an unknown pacer code");

endmodule

`default_nettype wire

/* verif/pulse_list_app_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "pulse_list_config.svh"

module pulse_list_app_tb;
  localparam int HALF_PERIOD = 50;
  localparam int RESET_CYCLES = 16;
  localparam int START_LIMIT = 2000;  // start strobe to running, upper bound
  localparam int SETTLE = 20;
  localparam int WATCHDOG_CYCLES = 5 * (RESET_CYCLES + 2 * START_LIMIT);
  localparam int PH_RESET = 0;
  localparam int PH_START = 1;
  localparam int PH_DATA = 2;
  localparam int PH_STOP = 3;
  localparam int PH_IDLE_STOP = 4;

  logic CLK = 1'b0;
  logic RESET;
  logic pc_msg_valid;
  logic [`PL_XB_W-1:0] pc_msg;
  logic pc_msg_ack;
  logic fpga_msg_valid;
  logic [`PL_XB_W-1:0] fpga_msg;
  logic app_running;
  logic app_error;
  logic [3:0] GPIO_LED;

  logic [31:0] lfsr = 32'h7b46_021f;
  int seen_reports = 0;  // controller reports seen so far
  pulse_list_pkg::ctrl_report_t [1:0] exp_q[$];  // expected status words

  pulse_list_app pulse_list_app_inst (
    .CLK(CLK), .RESET(RESET), .pc_msg_valid(pc_msg_valid), .pc_msg(pc_msg),
    .pc_msg_ack(pc_msg_ack), .fpga_msg_valid(fpga_msg_valid), .fpga_msg(fpga_msg),
    .app_running(app_running), .app_error(app_error), .GPIO_LED(GPIO_LED));

  bind pulse_list_app pulse_list_app_props pulse_list_app_props_inst (
    .CLK(CLK), .RESET(RESET), .pc_msg_valid(pc_msg_valid), .pc_msg_ack(pc_msg_ack),
    .fpga_msg_valid(fpga_msg_valid), .app_running(app_running),
    .app_error(app_error), .GPIO_LED(GPIO_LED));

  always #(HALF_PERIOD) CLK = ~CLK;

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Errors found");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic check_state(input string what, input pulse_list_pkg::pacer_state_e got,
                             input pulse_list_pkg::pacer_state_e exp);
    if (got != exp)
      stop_run($sformatf("ERR %0t: %s is %s, expected %s", $time, what, got.name(), exp.name()));
  endtask

  // state field only matters when the reported bit is set
  task automatic check_report(input string what, input pulse_list_pkg::ctrl_report_t got,
                              input pulse_list_pkg::ctrl_report_t exp);
    if (got.valid != exp.valid || (exp.valid && got.state != exp.state))
      stop_run($sformatf("ERR %0t: %s is %b/%0d, expected %b/%0d", $time, what,
                         got.valid, got.state, exp.valid, exp.state));
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp)
      stop_run($sformatf("ERR %0t: %s is %b, expected %b", $time, what, got, exp));
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // led code and number of controller reports once a phase has settled
  function automatic pulse_list_pkg::pacer_state_e predict(input int phase,
                                                           output int n_reports);
    pulse_list_pkg::pacer_state_e led;
    case (phase)
      PH_START, PH_DATA: led = pulse_list_pkg::PACER_INTERFRAME;
      default: led = pulse_list_pkg::PACER_STOPPED;
    endcase
    n_reports = 0;
    if (phase == PH_START) n_reports = 3;  // fill STOP, then STOP to both
    if (phase == PH_STOP) n_reports = 2;
    return led;
  endfunction

  function automatic pulse_list_pkg::ctrl_report_t reported(input pulse_list_pkg::ram_state_e s);
    return '{valid: 1'b1, state: s};
  endfunction

  task automatic queue_words(input int phase);
    pulse_list_pkg::ctrl_report_t none;
    none = '0;
    if (phase == PH_START) begin
      // controller 0 still writing when the fill closes
      exp_q.push_back({none, reported(pulse_list_pkg::RAM_WRITE)});
      // read-back ends by itself after the last address, copy still writing
      exp_q.push_back({reported(pulse_list_pkg::RAM_WRITE), reported(pulse_list_pkg::RAM_IDLE)});
    end else if (phase == PH_STOP) begin
      exp_q.push_back({reported(pulse_list_pkg::RAM_IDLE), reported(pulse_list_pkg::RAM_IDLE)});
    end
  endtask

  // status word compare
  always @(negedge CLK) begin
    pulse_list_pkg::ctrl_report_t [1:0] got;
    pulse_list_pkg::ctrl_report_t [1:0] exp;
    if (!RESET && fpga_msg_valid) begin
      got[0] = {fpga_msg[7], fpga_msg[2:0]};
      got[1] = {fpga_msg[15], fpga_msg[10:8]};
      if (exp_q.size() == 0) begin
        stop_run($sformatf("ERR %0t: unexpected status word %h", $time, fpga_msg));
      end else begin
        exp = exp_q.pop_front();
        check_flag("status word padding clear", (fpga_msg & 32'hffff_7878) == '0, 1'b1);
        check_report("controller 0 report", got[0], exp[0]);
        check_report("controller 1 report", got[1], exp[1]);
        seen_reports = seen_reports + int'(got[0].valid) + int'(got[1].valid);
      end
    end
  end

  task automatic send_word(input logic [31:0] w);
    logic [31:0] gap;
    take_bits(2, gap);  // 0 to 3 idle cycles
    repeat (int'(gap)) @(negedge CLK);
    pc_msg_valid = 1'b1;
    pc_msg = w;
    @(posedge CLK);
    check_flag("pc_msg_ack", pc_msg_ack, 1'b1);
    @(negedge CLK);
    pc_msg_valid = 1'b0;
  endtask

  task automatic send_cmd(input logic is_data, input logic start);
    logic [31:0] w;
    for (int i = 0; i < `PL_CMD_WORDS; i++) begin
      take_bits(32, w);
      if (i == 0) begin
        w[0] = is_data;
        w[6] = start;
      end
      send_word(w);
    end
  endtask

  task automatic wait_running();
    int n;
    n = 0;
    while (!app_running && !app_error) begin
      if (n == START_LIMIT) stop_run("timeout: app_running did not rise after start");
      n++;
      @(negedge CLK);
    end
  endtask

  task automatic wait_stopped();
    int n;
    n = 0;
    while (GPIO_LED != pulse_list_pkg::PACER_STOPPED) begin
      if (n == SETTLE) stop_run("timeout: pacer did not return to stopped");
      n++;
      @(negedge CLK);
    end
  endtask

  task automatic finish_phase(input int phase, input int base);
    pulse_list_pkg::pacer_state_e led;
    int n;
    int waited;
    led = predict(phase, n);
    waited = 0;
    while (exp_q.size() != 0) begin
      if (waited == SETTLE) stop_run("timeout: an expected status word did not arrive");
      waited++;
      @(posedge CLK);
    end
    repeat (SETTLE) @(negedge CLK);  // room for stray words
    check_state("GPIO_LED", pulse_list_pkg::pacer_state_e'(GPIO_LED), led);
    check_flag("app_running", app_running, led == pulse_list_pkg::PACER_INTERFRAME);
    check_flag("app_error", app_error, 1'b0);
    check_flag("fpga_msg_valid", fpga_msg_valid, 1'b0);
    if (seen_reports - base != n)
      stop_run($sformatf("ERR %0t: %0d controller reports, expected %0d", $time,
                         seen_reports - base, n));
  endtask

  task automatic run_start();
    int base;
    base = seen_reports;
    queue_words(PH_START);
    send_cmd(1'b0, 1'b1);
    wait_running();
    check_flag("app_error after start", app_error, 1'b0);
    finish_phase(PH_START, base);
  endtask

  initial begin
    int base;
    RESET = 1'b1;
    pc_msg_valid = 1'b0;
    pc_msg = '0;
    repeat (RESET_CYCLES) @(posedge CLK);
    @(negedge CLK);
    RESET = 1'b0;
    finish_phase(PH_RESET, seen_reports);
    run_start();
    base = seen_reports;
    send_cmd(1'b1, 1'b0);  // data type, would stop if decoded as control
    finish_phase(PH_DATA, base);
    base = seen_reports;
    queue_words(PH_STOP);
    send_cmd(1'b0, 1'b0);
    check_flag("app_running as stop strobe rises", app_running, 1'b1);
    @(negedge CLK);
    check_flag("app_running one edge after stop", app_running, 1'b0);
    wait_stopped();
    finish_phase(PH_STOP, base);
    base = seen_reports;
    send_cmd(1'b0, 1'b0);  // already stopped
    finish_phase(PH_IDLE_STOP, base);
    run_start();  // fill and check again from address 0
    $display("No errors");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    stop_run("timeout: the run did not finish within the watchdog limit");
  end

endmodule

`default_nettype wire
